//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := hist_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/hist_properties.sv
`timescale 1ns/1ns
`default_nettype none

module hist_properties import hist_types_pkg::*; (
    input logic       clk,
    input logic       combin_res,
    input logic       acc_req,
    input logic       ro_gnt,
    input logic       ro_rd_en,
    input logic       ro_wr_en,
    input logic       out_valid,
    input logic       out_last,
    input logic       frame_done,
    input logic       busy,
    input logic       rd_bank,
    input logic       acc_wr_en,
    input hist_addr_u acc_wr_addr
);

    hist_addr_s wr_fld;

    assign wr_fld = acc_wr_addr.fld;

    // readout touches the RAM only in its own granted, accumulator-free cycles
    grant_exclusive: assert property (@(posedge clk) disable iff (!combin_res)
        (ro_rd_en || ro_wr_en) |-> (ro_gnt && !acc_req))
        else $error("readout accessed the RAM in a cycle the accumulator owns");

    // nothing follows the final beat of a bank
    last_with_valid: assert property (@(posedge clk) disable iff (!combin_res)
        out_last |-> out_valid ##1 !out_valid)
        else $error("out_last without out_valid, or a beat after the last bin");

    // the final write of a frame lands in the frame_done cycle itself
    no_write_to_drain: assert property (@(posedge clk) disable iff (!combin_res)
        (acc_wr_en && busy && !frame_done) |-> (wr_fld.bank != rd_bank))
        else $error("accumulator wrote into the bank being read out");

endmodule

bind hist_top hist_properties props_i (
    .clk         (clk),
    .combin_res  (combin_res),
    .acc_req     (acc_bus.req),
    .ro_gnt      (ro_bus.gnt),
    .ro_rd_en    (ro_bus.rd_en),
    .ro_wr_en    (ro_bus.wr_en),
    .out_valid   (out_valid),
    .out_last    (out_last),
    .frame_done  (frame_done),
    .busy        (busy),
    .rd_bank     (rd_bank),
    .acc_wr_en   (acc_bus.wr_en),
    .acc_wr_addr (acc_bus.wr_addr)
);

`default_nettype wire

//--- bench/hist_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hist_tb import hist_types_pkg::*; ();

    localparam int BINS = 8;
    localparam int PIXELS = 4;
    localparam int HPP = 16;
    localparam int COUNT_W = 4;
    localparam int FRAME_HITS = PIXELS * HPP;
    localparam int BEATS = PIXELS * BINS;
    localparam int FRAMES = 9;
    localparam int ROWS = FRAMES * FRAME_HITS;
    localparam int NTESTS = 6;
    localparam int MAX_CNT = 2 ** COUNT_W - 1;

    logic               clk;
    logic               combin_res;
    logic               hit;
    bin_idx_t           bin;
    logic [COUNT_W-1:0] bin_count;
    logic               out_valid;
    logic               out_last;
    logic               frame_done;
    logic               his_num;
    logic               overrun;

    // stimulus table, one row per hit
    int row_gap [ROWS];
    int row_bin [ROWS];
    int row_tag [ROWS];
    int frame_tag [FRAMES];
    bit frame_ends_test [FRAMES];
    int n_rows;
    int n_frames;

    int model [2][PIXELS][BINS]; // reference counts per bank
    bit known [2][PIXELS][BINS]; // bin cleared once, value defined

    int hits_in_frame;
    int frames_filled;
    int frames_closed;
    int beat_idx;
    int ro_frame;
    bit ro_active;
    bit idle_pending;
    bit ovr_seen;
    int errs [1:NTESTS];
    int tests_done;
    int checks;
    int cycles;
    int cycle_limit;

    hist_top #(
        .BINS           (BINS),
        .PIXELS         (PIXELS),
        .HITS_PER_PIXEL (HPP),
        .COUNT_W        (COUNT_W)
    ) dut_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .bin        (bin),
        .bin_count  (bin_count),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .frame_done (frame_done),
        .his_num    (his_num),
        .overrun    (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a frame or readout never completed", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic string test_name(input int tag);
        case (tag)
            1: return "reset and flush";
            2: return "same bin back to back";
            3: return "saturation";
            4: return "banking and clearing";
            5: return "contention";
            default: return "overrun";
        endcase
    endfunction

    task automatic check_val(input string name, input int got, input int exp, input int tag);
        checks++;
        assert (got == exp) else begin
            $display("[ERROR] %0t ns %s = %0d, expected %0d", $time, name, got, exp);
            errs[tag]++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what, input int tag);
        checks++;
        assert (ok) else begin
            $display("[ERROR] %0t ns %s", $time, what);
            errs[tag]++;
        end
    endtask

    task automatic add_frame(input int tag, input int gap, input int mode, input bit last);
        int b;
        for (int i = 0; i < FRAME_HITS; i++) begin
            case (mode)
                0: b = i % BINS;
                1: b = (i % HPP < 14) ? 2 : 6;
                2: b = (i < HPP) ? 1 : i % BINS; // pixel 0 takes all 16 on bin 1
                3: b = (i % 4 < 2) ? i % 4 : i % 4 + 1;
                4: b = (i % 2 == 1) ? 7 : 5;
                default: b = int'($urandom % BINS);
            endcase
            row_gap[n_rows] = gap;
            row_bin[n_rows] = b;
            row_tag[n_rows] = tag;
            n_rows++;
        end
        frame_tag[n_frames] = tag;
        frame_ends_test[n_frames] = last;
        n_frames++;
    endtask

    task automatic drive_row(input int i);
        int pix;
        int bank;
        int b;
        repeat (row_gap[i]) begin
            @(negedge clk);
            hit = 1'b0;
        end
        @(negedge clk);
        hit = 1'b1;
        bin = bin_idx_t'(row_bin[i]);
        pix = hits_in_frame / HPP;
        bank = frames_filled % 2;
        b = row_bin[i];
        model[bank][pix][b] = (model[bank][pix][b] < MAX_CNT) ? model[bank][pix][b] + 1 : MAX_CNT;
        hits_in_frame++;
        if (hits_in_frame == FRAME_HITS) begin
            hits_in_frame = 0;
            frames_filled++;
        end
    endtask

    task automatic finish_readout();
        int tag;
        tag = frame_tag[ro_frame];
        idle_pending = 1'b1; // busy drops one cycle after out_last
        if (frame_ends_test[ro_frame]) begin
            check_val("overrun", int'(overrun), int'(ovr_seen), tag);
            $display("test %0d %-22s %s, %0d errors", tag, test_name(tag),
                     (errs[tag] == 0) ? "passed" : "failed", errs[tag]);
            tests_done++;
        end
    endtask

    task automatic take_beat();
        int tag;
        int bank;
        int pix;
        int bn;
        tag = frame_tag[ro_frame];
        if (!ro_active) begin
            check_cond(1'b0, "readout beat while no readout was running", tag);
            return;
        end
        bank = ro_frame % 2;
        // after an overrun the cut bank leaves stale words behind
        if (!ovr_seen) begin
            if (beat_idx >= BEATS) begin
                check_cond(1'b0, "more beats than bins in one readout", tag);
            end else begin
                pix = beat_idx / BINS;
                bn = beat_idx % BINS;
                if (known[bank][pix][bn]) begin
                    check_val($sformatf("bin_count[bank%0d p%0d b%0d]", bank, pix, bn),
                              int'(bin_count), model[bank][pix][bn], tag);
                end
                check_val("out_last", int'(out_last), int'(beat_idx == BEATS - 1), tag);
                model[bank][pix][bn] = 0;
                known[bank][pix][bn] = 1'b1;
            end
        end
        beat_idx++;
        if (out_last) begin
            finish_readout();
        end
    endtask

    task automatic close_frame();
        int tag;
        tag = frame_tag[frames_closed];
        check_cond(frames_closed + 1 == frames_filled, "frame_done without a full frame of hits",
                   tag);
        check_val("his_num", int'(his_num), (frames_closed + 1) % 2, tag);
        if (ro_active) begin
            ovr_seen = 1'b1;
            check_cond(tag == 6, "previous readout still running at frame_done", tag);
        end
        ro_active = 1'b1;
        idle_pending = 1'b0;
        beat_idx = 0;
        ro_frame = frames_closed;
        frames_closed++;
    endtask

    always @(negedge clk) begin
        if (combin_res) begin
            if (idle_pending) begin
                ro_active = 1'b0;
                idle_pending = 1'b0;
            end
            if (out_valid) begin
                take_beat(); // old readout beat before a new start
            end
            if (frame_done) begin
                close_frame();
            end
        end
    end

    initial begin
        int total;
        int failed;
        void'($urandom(32'h4b48_48da));
        combin_res = 1'b0;
        hit = 1'b0;
        bin = '0;
        n_rows = 0;
        n_frames = 0;
        hits_in_frame = 0;
        frames_filled = 0;
        frames_closed = 0;
        beat_idx = 0;
        ro_frame = 0;
        ro_active = 1'b0;
        idle_pending = 1'b0;
        ovr_seen = 1'b0;
        tests_done = 0;
        checks = 0;
        cycles = 0;
        cycle_limit = 0;
        for (int t = 1; t <= NTESTS; t++) begin
            errs[t] = 0;
        end
        foreach (model[k, p, b]) begin
            model[k][p][b] = 0;
            known[k][p][b] = 1'b0;
        end

        add_frame(1, 3, 0, 1'b0); // flush bank 0
        add_frame(1, 3, 0, 1'b1); // flush bank 1
        add_frame(2, 0, 1, 1'b1);
        add_frame(3, 0, 2, 1'b1);
        add_frame(4, 1, 3, 1'b0);
        add_frame(4, 2, 4, 1'b1);
        add_frame(5, 2, 5, 1'b1); // gap 2 leaves idle slots for the readout
        add_frame(6, 0, 5, 1'b0);
        add_frame(6, 0, 5, 1'b1);

        cycle_limit = 100 + 64 * n_frames;
        for (int i = 0; i < n_rows; i++) begin
            cycle_limit += row_gap[i] + 1;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        check_val("his_num", int'(his_num), 0, 1);
        check_val("frame_done", int'(frame_done), 0, 1);
        check_val("out_valid", int'(out_valid), 0, 1);
        check_val("overrun", int'(overrun), 0, 1);

        for (int i = 0; i < n_rows; i++) begin
            // contention test runs straight into the previous readout
            if (i > 0 && row_tag[i] != row_tag[i-1] && row_tag[i] != 5) begin
                @(negedge clk);
                hit = 1'b0;
                while (tests_done < row_tag[i] - 1) begin
                    @(negedge clk);
                end
            end
            drive_row(i);
        end
        @(negedge clk);
        hit = 1'b0;
        while (tests_done < NTESTS) begin
            @(negedge clk);
        end

        total = 0;
        failed = 0;
        for (int t = 1; t <= NTESTS; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d", NTESTS, failed, checks, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/hist_cfg_pkg.sv
hdl/hist_types_pkg.sv
hdl/hist_mem_if.sv
hdl/hist_ram.sv
hdl/mem_arbiter.sv
hdl/acq_sequencer.sv
hdl/bin_accumulator.sv
hdl/hist_readout.sv
hdl/hist_top.sv
bench/hist_properties.sv
bench/hist_tb.sv

//--- hdl/acq_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module acq_sequencer import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int PIXELS         = PIXELS_DEF,
    parameter int HITS_PER_PIXEL = HITS_PER_PIXEL_DEF
) (
    input  logic     clk,
    input  logic     combin_res,
    input  logic     hit,
    input  logic     busy,
    output logic     cur_bank,
    output logic     rd_bank,
    output pix_idx_t cur_pixel,
    output logic     frame_done,
    output logic     start,
    output logic     his_num,
    output logic     overrun
);

    localparam int HIT_W = idx_w(HITS_PER_PIXEL);

    logic [HIT_W-1:0] hit_cnt;
    logic             pixel_end; // this hit closes the pixel
    logic             frame_end; // and the frame

    assign pixel_end = hit && (hit_cnt == HIT_W'(HITS_PER_PIXEL - 1));
    assign frame_end = pixel_end && (cur_pixel == pix_idx_t'(PIXELS - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt    <= '0;
            cur_pixel  <= '0;
            frame_done <= 1'b0;
            his_num    <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            frame_done <= frame_end;
            if (frame_end) begin
                his_num <= ~his_num; // swap banks with the frame_done pulse
            end
            if (frame_done && busy) begin
                overrun <= 1'b1; // sticky
            end
            if (pixel_end) begin
                hit_cnt   <= '0;
                cur_pixel <= frame_end ? '0 : cur_pixel + 1'b1;
            end else if (hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    // accumulator fills his_num, the other bank drains
    assign cur_bank = his_num;
    assign rd_bank  = ~his_num;
    assign start    = frame_done;

endmodule

`default_nettype wire

//--- hdl/bin_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module bin_accumulator import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int COUNT_W = COUNT_W_DEF
) (
    input logic           clk,
    input logic           combin_res,
    input logic           hit,
    input bin_idx_t       bin,
    input logic           cur_bank,
    input pix_idx_t       cur_pixel,
    hist_mem_if.requester bus
);

    hist_addr_u         hit_addr;
    hist_addr_u         s1_addr;   // address read last cycle
    logic               s1_valid;
    hist_addr_u         fwd_addr;  // address written last cycle
    logic               fwd_valid;
    logic [COUNT_W-1:0] fwd_data;
    logic [COUNT_W-1:0] base_count;

    always_comb begin
        hit_addr.fld.bank  = cur_bank;
        hit_addr.fld.pixel = cur_pixel;
        hit_addr.fld.bin   = bin;
    end

    // stage one reads, stage two writes
    assign bus.req     = hit | s1_valid;
    assign bus.rd_en   = hit & bus.gnt;
    assign bus.rd_addr = hit_addr;

    // the RAM returned the stale count when the previous write hit the same bin
    assign base_count = (fwd_valid && (fwd_addr.flat == s1_addr.flat)) ? fwd_data
                                                                       : bus.rd_data;

    assign bus.wr_en   = s1_valid & bus.gnt;
    assign bus.wr_addr = s1_addr;
    assign bus.wr_data = (&base_count) ? base_count : base_count + 1'b1; // saturate

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1_valid  <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            s1_valid  <= bus.rd_en;
            fwd_valid <= bus.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr  <= hit_addr;
        fwd_addr <= s1_addr;
        fwd_data <= bus.wr_data;
    end

endmodule

`default_nettype wire

//--- hdl/hist_cfg_pkg.sv
`default_nettype none

package hist_cfg_pkg;

    // defaults, overridden from hist_top
    localparam int BINS_DEF           = 8;
    localparam int PIXELS_DEF         = 4;
    localparam int HITS_PER_PIXEL_DEF = 16;
    localparam int COUNT_W_DEF        = 4;

    // largest geometry the address word can hold
    localparam int BINS_MAX   = 64;
    localparam int PIXELS_MAX = 256;

    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    localparam int BIN_W    = idx_w(BINS_MAX);
    localparam int PIX_W    = idx_w(PIXELS_MAX);
    localparam int BIN_SPAN = 2 ** BIN_W;       // bin slots per pixel in the address map
    localparam int ADDR_W   = 1 + PIX_W + BIN_W; // bank + pixel + bin

endpackage

`default_nettype wire

//--- hdl/hist_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hist_mem_if import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int COUNT_W = COUNT_W_DEF
) ();

    logic               req;
    logic               gnt;     // same-cycle grant
    logic               rd_en;
    hist_addr_u         rd_addr;
    logic [COUNT_W-1:0] rd_data; // one cycle after rd_en
    logic               wr_en;
    hist_addr_u         wr_addr;
    logic [COUNT_W-1:0] wr_data;

    modport requester (
        output req, rd_en, rd_addr, wr_en, wr_addr, wr_data,
        input  gnt, rd_data
    );

    modport arbiter (
        input  req, rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output gnt, rd_data
    );

    modport ram (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

//--- hdl/hist_ram.sv
`timescale 1ns/1ns
`default_nettype none

module hist_ram import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int BINS    = BINS_DEF,
    parameter int PIXELS  = PIXELS_DEF,
    parameter int COUNT_W = COUNT_W_DEF
) (
    input logic    clk,
    hist_mem_if.ram mem
);

    localparam int DEPTH = 2 * PIXELS * BINS; // both banks
    localparam int IDX_W = idx_w(DEPTH);

    logic [COUNT_W-1:0] mem_q [DEPTH];
    logic [IDX_W-1:0]   rd_idx;
    logic [IDX_W-1:0]   wr_idx;

    // packs the used part of each field densely
    function automatic logic [IDX_W-1:0] ram_index(input hist_addr_u a);
        int idx;
        idx = int'(a.fld.bank) * PIXELS * BINS + int'(a.fld.pixel) * BINS + int'(a.fld.bin);
        return IDX_W'(idx);
    endfunction

    assign rd_idx = ram_index(mem.rd_addr);
    assign wr_idx = ram_index(mem.wr_addr);

    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= mem_q[rd_idx]; // old data on collision
        end
        if (mem.wr_en) begin
            mem_q[wr_idx] <= mem.wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hist_readout.sv
`timescale 1ns/1ns
`default_nettype none

module hist_readout import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int BINS    = BINS_DEF,
    parameter int PIXELS  = PIXELS_DEF,
    parameter int COUNT_W = COUNT_W_DEF
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               start,
    input  logic               rd_bank,
    hist_mem_if.requester      bus,
    output logic [COUNT_W-1:0] bin_count,
    output logic               out_valid,
    output logic               out_last,
    output logic               busy
);

    hist_addr_u         first_addr;
    hist_addr_u         rd_ptr;     // next bin to read
    hist_addr_u         clr_ptr;    // oldest bin not yet cleared
    logic               rd_active;
    logic               ret_valid;  // read data on the bus this cycle
    logic               hold_valid; // returned word waiting for a slot
    logic [COUNT_W-1:0] hold_data;
    logic               beat_avail;
    logic [COUNT_W-1:0] beat_data;

    // flat walk, skipping the unused bin slots at each pixel end
    function automatic hist_addr_u step_addr(input hist_addr_u a);
        hist_addr_u n;
        if (a.fld.bin == bin_idx_t'(BINS - 1)) begin
            n.flat = a.flat + hist_flat_t'(BIN_SPAN - BINS + 1);
        end else begin
            n.flat = a.flat + 1'b1;
        end
        return n;
    endfunction

    function automatic logic is_last(input hist_addr_u a);
        return (a.fld.pixel == pix_idx_t'(PIXELS - 1)) && (a.fld.bin == bin_idx_t'(BINS - 1));
    endfunction

    always_comb begin
        first_addr.fld.bank  = rd_bank;
        first_addr.fld.pixel = '0;
        first_addr.fld.bin   = '0;
    end

    assign beat_avail = hold_valid | ret_valid; // never both at once
    assign beat_data  = hold_valid ? hold_data : bus.rd_data;

    assign bus.req     = rd_active | beat_avail;
    assign bus.rd_en   = bus.gnt & rd_active & ~start;
    assign bus.rd_addr = rd_ptr;
    assign bus.wr_en   = bus.gnt & beat_avail; // clear as the beat goes out
    assign bus.wr_addr = clr_ptr;
    assign bus.wr_data = '0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_active  <= 1'b0;
            ret_valid  <= 1'b0;
            hold_valid <= 1'b0;
            busy       <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            ret_valid <= bus.rd_en;
            out_valid <= bus.wr_en;
            out_last  <= bus.wr_en & is_last(clr_ptr);
            if (start) begin
                rd_active  <= 1'b1;
                hold_valid <= 1'b0; // drop leftovers of an overrun bank
                busy       <= 1'b1;
            end else begin
                if (bus.rd_en && is_last(rd_ptr)) begin
                    rd_active <= 1'b0;
                end
                hold_valid <= beat_avail & ~bus.wr_en;
                if (out_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_ptr  <= first_addr;
            clr_ptr <= first_addr;
        end else begin
            if (bus.rd_en) begin
                rd_ptr <= step_addr(rd_ptr);
            end
            if (bus.wr_en) begin
                clr_ptr <= step_addr(clr_ptr);
            end
        end
        if (ret_valid && !hold_valid) begin
            hold_data <= bus.rd_data;
        end
        if (bus.wr_en) begin
            bin_count <= beat_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hist_top.sv
`timescale 1ns/1ns
`default_nettype none

module hist_top import hist_cfg_pkg::*, hist_types_pkg::*; #(
    parameter int BINS           = BINS_DEF,
    parameter int PIXELS         = PIXELS_DEF,
    parameter int HITS_PER_PIXEL = HITS_PER_PIXEL_DEF,
    parameter int COUNT_W        = COUNT_W_DEF
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               hit,
    input  bin_idx_t           bin,
    output logic [COUNT_W-1:0] bin_count,
    output logic               out_valid,
    output logic               out_last,
    output logic               frame_done,
    output logic               his_num,
    output logic               overrun
);

    logic     cur_bank;
    logic     rd_bank;
    logic     start;
    logic     busy;
    pix_idx_t cur_pixel;

    hist_mem_if #(.COUNT_W(COUNT_W)) acc_bus ();
    hist_mem_if #(.COUNT_W(COUNT_W)) ro_bus ();
    hist_mem_if #(.COUNT_W(COUNT_W)) ram_bus ();

    assign ram_bus.gnt = ram_bus.req; // single RAM, takes every request

    acq_sequencer #(
        .PIXELS         (PIXELS),
        .HITS_PER_PIXEL (HITS_PER_PIXEL)
    ) seq_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .busy       (busy),
        .cur_bank   (cur_bank),
        .rd_bank    (rd_bank),
        .cur_pixel  (cur_pixel),
        .frame_done (frame_done),
        .start      (start),
        .his_num    (his_num),
        .overrun    (overrun)
    );

    bin_accumulator #(.COUNT_W(COUNT_W)) acc_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .bin        (bin),
        .cur_bank   (cur_bank),
        .cur_pixel  (cur_pixel),
        .bus        (acc_bus.requester)
    );

    hist_readout #(
        .BINS    (BINS),
        .PIXELS  (PIXELS),
        .COUNT_W (COUNT_W)
    ) ro_i (
        .clk        (clk),
        .combin_res (combin_res),
        .start      (start),
        .rd_bank    (rd_bank),
        .bus        (ro_bus.requester),
        .bin_count  (bin_count),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .busy       (busy)
    );

    mem_arbiter arb_i (
        .clk        (clk),
        .combin_res (combin_res),
        .acc        (acc_bus.arbiter),
        .ro         (ro_bus.arbiter),
        .ram        (ram_bus.requester)
    );

    hist_ram #(
        .BINS    (BINS),
        .PIXELS  (PIXELS),
        .COUNT_W (COUNT_W)
    ) ram_i (
        .clk (clk),
        .mem (ram_bus.ram)
    );

endmodule

`default_nettype wire

//--- hdl/hist_types_pkg.sv
`default_nettype none

package hist_types_pkg;

    import hist_cfg_pkg::*;

    typedef logic [BIN_W-1:0]  bin_idx_t;
    typedef logic [PIX_W-1:0]  pix_idx_t;
    typedef logic [ADDR_W-1:0] hist_flat_t;

    // field view, bank in the msb
    typedef struct packed {
        logic     bank;
        pix_idx_t pixel;
        bin_idx_t bin;
    } hist_addr_s;

    // same word, fields or one flat index
    typedef union packed {
        hist_addr_s fld;
        hist_flat_t flat;
    } hist_addr_u;

endpackage

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input logic           clk,
    input logic           combin_res,
    hist_mem_if.arbiter   acc,
    hist_mem_if.arbiter   ro,
    hist_mem_if.requester ram
);

    logic rd_owner_ro; // readout issued the read now returning

    assign ram.req = acc.req | ro.req;

    // accumulator first, readout only on idle cycles
    assign acc.gnt = acc.req & ram.gnt;
    assign ro.gnt  = ro.req & ~acc.req & ram.gnt;

    assign ram.rd_en   = acc.gnt ? acc.rd_en   : (ro.gnt & ro.rd_en);
    assign ram.rd_addr = acc.gnt ? acc.rd_addr : ro.rd_addr;
    assign ram.wr_en   = acc.gnt ? acc.wr_en   : (ro.gnt & ro.wr_en);
    assign ram.wr_addr = acc.gnt ? acc.wr_addr : ro.wr_addr;
    assign ram.wr_data = acc.gnt ? acc.wr_data : ro.wr_data;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_owner_ro <= 1'b0;
        end else if (ram.rd_en) begin
            rd_owner_ro <= ro.gnt;
        end
    end

    // return path, only the owner sees the word
    assign acc.rd_data = rd_owner_ro ? '0 : ram.rd_data;
    assign ro.rd_data  = rd_owner_ro ? ram.rd_data : '0;

endmodule

`default_nettype wire
